// ==== logic/commit_pkg.sv ====
package commit_pkg;

    // data and address width
    localparam int XLEN = 32;

    // bit positions in the 16-bit cause vector
    // lower index wins
    typedef enum logic [3:0] {
        IDX_INT   = 4'd0,
        IDX_ADEF  = 4'd1,
        IDX_ITLBR = 4'd2,
        IDX_PIF   = 4'd3,
        IDX_IPPI  = 4'd4,
        IDX_SYS   = 4'd5,
        IDX_BRK   = 4'd6,
        IDX_INE   = 4'd7,
        IDX_IPE   = 4'd8,
        IDX_ALE   = 4'd9,
        IDX_ADEM  = 4'd10,
        IDX_DTLBR = 4'd11,
        IDX_PME   = 4'd12,
        IDX_DPPI  = 4'd13,
        IDX_PIS   = 4'd14,
        IDX_PIL   = 4'd15
    } excp_idx_e;

    // estat ecode field
    typedef enum logic [5:0] {
        ECODE_INT  = 6'h00,
        ECODE_PIL  = 6'h01,
        ECODE_PIS  = 6'h02,
        ECODE_PIF  = 6'h03,
        ECODE_PME  = 6'h04,
        ECODE_PPI  = 6'h07,
        ECODE_ADE  = 6'h08,
        ECODE_ALE  = 6'h09,
        ECODE_SYS  = 6'h0B,
        ECODE_BRK  = 6'h0C,
        ECODE_INE  = 6'h0D,
        ECODE_IPE  = 6'h0E,
        ECODE_TLBR = 6'h3F
    } ecode_e;

    // esubcode splits ADE into fetch and memory flavours
    localparam logic [8:0] ESUBCODE_ADEF = 9'd0;
    localparam logic [8:0] ESUBCODE_ADEM = 9'd1;

    // csr numbers seen on the write strobe
    typedef enum logic [13:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_BADV   = 14'h007,
        CSR_EENTRY = 14'h00C,
        CSR_TCFG   = 14'h041,
        CSR_TICLR  = 14'h044
    } csr_num_e;

    // commit control states
    typedef enum logic [1:0] {
        CS_RUN,
        CS_WAIT_ICACHE,
        CS_RECOVER
    } commit_state_e;

    // tcfg layout
    localparam int TCFG_EN_BIT       = 0;
    localparam int TCFG_PERIODIC_BIT = 1;
    localparam int TCFG_INITVAL_LSB  = 2;

    // ticlr clear bit
    localparam int TICLR_CLR_BIT = 0;

    // ie in crmd, pie in prmd, same slot
    localparam int CRMD_IE_BIT = 2;

    // refetch bubble after a flush
    localparam int RECOVER_CYCLES = 1;
    localparam int RECOVER_CNT_W  = (RECOVER_CYCLES > 1) ? $clog2(RECOVER_CYCLES) : 1;

endpackage

// ==== logic/excp_encode.sv ====
`timescale 1ns/1ns

module excp_encode import commit_pkg::*; (
    input  logic [15:0]     excp_num,
    input  logic            irq,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] mem_addr,
    input  logic            left_valid,
    output ecode_e          ecode,
    output logic [8:0]      esubcode,
    output logic [XLEN-1:0] badv,
    output logic            badv_valid
);

    // cause vector with the interrupt folded in
    logic [15:0] cause;
    logic        hit;
    excp_idx_e   sel;
    // where badv comes from
    logic        from_pc;
    logic        from_mem;

    // pending interrupt joins bit 0
    always_comb begin
        cause = excp_num;
        cause[IDX_INT] = excp_num[IDX_INT] | irq;
    end

    // scan from the top, last hit is the lowest index
    always_comb begin
        hit = 1'b0;
        sel = IDX_INT;
        for (int i = 15; i >= 0; i--) begin
            if (cause[i]) begin
                hit = 1'b1;
                sel = excp_idx_e'(i);
            end
        end
    end

    // ecode, esubcode and badv source per winning cause
    always_comb begin
        ecode    = ECODE_INT;
        esubcode = '0;
        from_pc  = 1'b0;
        from_mem = 1'b0;
        if (hit) begin
            case (sel)
                IDX_INT:   ecode = ECODE_INT;
                // fetch side, faulting address is the pc
                IDX_ADEF: begin
                    ecode    = ECODE_ADE;
                    esubcode = ESUBCODE_ADEF;
                    from_pc  = 1'b1;
                end
                IDX_ITLBR: begin
                    ecode   = ECODE_TLBR;
                    from_pc = 1'b1;
                end
                IDX_PIF: begin
                    ecode   = ECODE_PIF;
                    from_pc = 1'b1;
                end
                IDX_IPPI: begin
                    ecode   = ECODE_PPI;
                    from_pc = 1'b1;
                end
                // no address attached
                IDX_SYS:   ecode = ECODE_SYS;
                IDX_BRK:   ecode = ECODE_BRK;
                IDX_INE:   ecode = ECODE_INE;
                IDX_IPE:   ecode = ECODE_IPE;
                // memory side, faulting address from the lsu
                IDX_ALE: begin
                    ecode    = ECODE_ALE;
                    from_mem = 1'b1;
                end
                IDX_ADEM: begin
                    ecode    = ECODE_ADE;
                    esubcode = ESUBCODE_ADEM;
                    from_mem = 1'b1;
                end
                IDX_DTLBR: begin
                    ecode    = ECODE_TLBR;
                    from_mem = 1'b1;
                end
                IDX_PME: begin
                    ecode    = ECODE_PME;
                    from_mem = 1'b1;
                end
                IDX_DPPI: begin
                    ecode    = ECODE_PPI;
                    from_mem = 1'b1;
                end
                IDX_PIS: begin
                    ecode    = ECODE_PIS;
                    from_mem = 1'b1;
                end
                IDX_PIL: begin
                    ecode    = ECODE_PIL;
                    from_mem = 1'b1;
                end
            endcase
        end
    end

    assign badv = from_pc ? pc : (from_mem ? mem_addr : '0);
    // only meaningful with a live instruction at the head
    assign badv_valid = (from_pc | from_mem) & left_valid;

endmodule

// ==== logic/commit_ctrl.sv ====
`timescale 1ns/1ns

module commit_ctrl import commit_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    input  logic head_excp,
    input  logic icache_busy,
    input  logic right_ready,
    input  logic left_valid,
    output logic stall,
    output logic fire
);

    commit_state_e            state;
    commit_state_e            state_nxt;
    // bubble length counter
    logic [RECOVER_CNT_W-1:0] rcnt;
    // flush can go this cycle
    logic                     can_fire;

    // live head, consumer ready, icache idle
    assign can_fire = left_valid & head_excp & right_ready & ~icache_busy;

    always_comb begin
        state_nxt = state;
        stall     = 1'b0;
        fire      = 1'b0;
        case (state)
            CS_RUN: begin
                if (can_fire) begin
                    fire      = 1'b1;
                    state_nxt = CS_RECOVER;
                end else if (head_excp & icache_busy) begin
                    // icache still refilling, hold the head
                    stall     = 1'b1;
                    state_nxt = CS_WAIT_ICACHE;
                end
            end
            CS_WAIT_ICACHE: begin
                if (can_fire) begin
                    fire      = 1'b1;
                    state_nxt = CS_RECOVER;
                end else if (!head_excp) begin
                    // head went away, nothing to flush
                    state_nxt = CS_RUN;
                end else begin
                    stall = icache_busy;
                end
            end
            CS_RECOVER: begin
                // refetch bubble
                stall = 1'b1;
                if (rcnt == '0) begin
                    state_nxt = CS_RUN;
                end
            end
            default: begin
                state_nxt = CS_RUN;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= CS_RUN;
        end else begin
            state <= state_nxt;
        end
    end

    // arm on fire, count down while recovering
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rcnt <= '0;
        end else if (fire) begin
            rcnt <= RECOVER_CNT_W'(RECOVER_CYCLES - 1);
        end else if (state == CS_RECOVER && rcnt != '0) begin
            rcnt <= rcnt - 1'b1;
        end
    end

endmodule

// ==== logic/stable_timer.sv ====
`timescale 1ns/1ns

module stable_timer import commit_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            csr_we,
    input  csr_num_e        csr_num,
    input  logic [XLEN-1:0] csr_wdata,
    output logic            timer_pending
);

    // tcfg fields kept apart
    logic                             tcfg_periodic;
    logic [XLEN-TCFG_INITVAL_LSB-1:0] tcfg_initval;
    // counting, cleared on one-shot expiry
    logic                             cnt_en;
    logic [XLEN-1:0]                  tval;
    logic                             tcfg_wr;
    logic                             ticlr_wr;
    logic                             expire;

    assign tcfg_wr  = csr_we & (csr_num == CSR_TCFG);
    assign ticlr_wr = csr_we & (csr_num == CSR_TICLR) & csr_wdata[TICLR_CLR_BIT];
    // reached zero last edge
    assign expire   = cnt_en & (tval == '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
            cnt_en        <= 1'b0;
            tval          <= '0;
        end else if (tcfg_wr) begin
            tcfg_periodic <= csr_wdata[TCFG_PERIODIC_BIT];
            tcfg_initval  <= csr_wdata[XLEN-1:TCFG_INITVAL_LSB];
            cnt_en        <= csr_wdata[TCFG_EN_BIT];
            tval          <= XLEN'(csr_wdata[XLEN-1:TCFG_INITVAL_LSB]);
        end else if (expire) begin
            // periodic reloads, one-shot stops
            if (tcfg_periodic) begin
                tval <= XLEN'(tcfg_initval);
            end else begin
                cnt_en <= 1'b0;
            end
        end else if (cnt_en) begin
            tval <= tval - 1'b1;
        end
    end

    // sticky until ticlr, a fresh expiry wins
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            timer_pending <= 1'b0;
        end else if (expire && !tcfg_wr) begin
            timer_pending <= 1'b1;
        end else if (ticlr_wr) begin
            timer_pending <= 1'b0;
        end
    end

endmodule

// ==== logic/excp_csr.sv ====
`timescale 1ns/1ns

module excp_csr import commit_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            csr_we,
    input  csr_num_e        csr_num,
    input  logic [XLEN-1:0] csr_wdata,
    input  logic            excp_commit,
    input  logic            ertn_commit,
    input  logic [XLEN-1:0] pc,
    input  ecode_e          ecode,
    input  logic [8:0]      esubcode,
    input  logic [XLEN-1:0] badv,
    input  logic            badv_valid,
    input  logic            timer_pending,
    output logic            irq,
    output logic [XLEN-1:0] flush_pc,
    output logic            crmd_ie
);

    // saved ie
    logic            prmd_pie;
    // exception payload
    logic [XLEN-1:0] era;
    logic [XLEN-1:0] eentry;
    ecode_e          estat_ecode;
    logic [8:0]      estat_esubcode;
    logic [XLEN-1:0] badv_q;
    // estat timer interrupt status
    logic            estat_ti;
    // decoded write strobes
    logic            crmd_wr;
    logic            prmd_wr;
    logic            era_wr;
    logic            eentry_wr;

    assign crmd_wr   = csr_we & (csr_num == CSR_CRMD);
    assign prmd_wr   = csr_we & (csr_num == CSR_PRMD);
    assign era_wr    = csr_we & (csr_num == CSR_ERA);
    assign eentry_wr = csr_we & (csr_num == CSR_EENTRY);

    // timer line mirrored into estat
    assign estat_ti = timer_pending;
    assign irq      = estat_ti & crmd_ie;

    // ertn returns to era, everything else to the handler
    assign flush_pc = ertn_commit ? era : eentry;

    // mode bits, commit events beat csr writes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            crmd_ie  <= 1'b0;
            prmd_pie <= 1'b0;
        end else if (excp_commit) begin
            prmd_pie <= crmd_ie;
            crmd_ie  <= 1'b0;
        end else if (ertn_commit) begin
            crmd_ie <= prmd_pie;
        end else begin
            if (crmd_wr) begin
                crmd_ie <= csr_wdata[CRMD_IE_BIT];
            end
            if (prmd_wr) begin
                prmd_pie <= csr_wdata[CRMD_IE_BIT];
            end
        end
    end

    // return address
    always_ff @(posedge clk) begin
        if (excp_commit) begin
            era <= pc;
        end else if (era_wr) begin
            era <= csr_wdata;
        end
    end

    // handler entry
    always_ff @(posedge clk) begin
        if (eentry_wr) begin
            eentry <= csr_wdata;
        end
    end

    // cause and bad address captured on entry
    always_ff @(posedge clk) begin
        if (excp_commit) begin
            estat_ecode    <= ecode;
            estat_esubcode <= esubcode;
            if (badv_valid) begin
                badv_q <= badv;
            end
        end
    end

endmodule

// ==== logic/wb_stage.sv ====
`timescale 1ns/1ns

module wb_stage import commit_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            left_valid,
    input  logic            right_ready,
    input  logic            icache_busy,
    input  logic [XLEN-1:0] pc,
    input  logic            inst_valid,
    input  logic            wreg_en,
    input  logic [4:0]      wreg_index,
    input  logic [XLEN-1:0] mem_result,
    input  logic [XLEN-1:0] mem_addr,
    input  logic [15:0]     excp_num,
    input  logic            ertn,
    input  logic            csr_we,
    input  csr_num_e        csr_num,
    input  logic [XLEN-1:0] csr_wdata,
    output logic            left_ready,
    output logic            right_valid,
    output logic            wreg_en_out,
    output logic [4:0]      wreg_index_out,
    output logic [XLEN-1:0] wreg_data,
    output logic            excp_flush,
    output logic            ertn_flush,
    output logic [XLEN-1:0] flush_pc,
    output ecode_e          ecode,
    output logic [8:0]      esubcode,
    output logic [XLEN-1:0] badv,
    output logic            badv_valid,
    output logic            crmd_ie
);

    logic irq;
    logic has_excp;
    logic head_excp;
    logic stall;
    logic fire;
    logic timer_pending;

    // any cause or a taken interrupt
    assign has_excp  = (|excp_num) | irq;
    assign head_excp = left_valid & (has_excp | ertn);

    // handshake, held while the ctrl fsm stalls
    assign left_ready  = right_ready & ~stall;
    assign right_valid = left_valid & ~stall;

    // exception wins over ertn on the same head
    assign excp_flush = fire & has_excp;
    assign ertn_flush = fire & ~has_excp;

    // write port and bypass, killed on excepting heads
    assign wreg_en_out    = wreg_en & inst_valid & left_valid & left_ready & ~head_excp;
    assign wreg_index_out = wreg_index;
    assign wreg_data      = mem_result;

    excp_encode u_encode (
        .excp_num   (excp_num),
        .irq        (irq),
        .pc         (pc),
        .mem_addr   (mem_addr),
        .left_valid (left_valid),
        .ecode      (ecode),
        .esubcode   (esubcode),
        .badv       (badv),
        .badv_valid (badv_valid)
    );

    commit_ctrl u_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .head_excp   (head_excp),
        .icache_busy (icache_busy),
        .right_ready (right_ready),
        .left_valid  (left_valid),
        .stall       (stall),
        .fire        (fire)
    );

    stable_timer u_timer (
        .clk           (clk),
        .arst_n        (arst_n),
        .csr_we        (csr_we),
        .csr_num       (csr_num),
        .csr_wdata     (csr_wdata),
        .timer_pending (timer_pending)
    );

    excp_csr u_csr (
        .clk           (clk),
        .arst_n        (arst_n),
        .csr_we        (csr_we),
        .csr_num       (csr_num),
        .csr_wdata     (csr_wdata),
        .excp_commit   (excp_flush),
        .ertn_commit   (ertn_flush),
        .pc            (pc),
        .ecode         (ecode),
        .esubcode      (esubcode),
        .badv          (badv),
        .badv_valid    (badv_valid),
        .timer_pending (timer_pending),
        .irq           (irq),
        .flush_pc      (flush_pc),
        .crmd_ie       (crmd_ie)
    );

endmodule

// ==== test/wb_stage_tb.sv ====
`timescale 1ns/1ns

module wb_stage_tb import commit_pkg::*; ();

    localparam int N_TESTS    = 14;
    localparam int MAX_CYCLES = N_TESTS * 40;
    // handler address, written by the first entry
    localparam logic [XLEN-1:0] EENTRY_VAL = 32'h1C00_8000;
    // expected badv source
    localparam int SRC_NONE = 0;
    localparam int SRC_PC   = 1;
    localparam int SRC_MEM  = 2;
    // expected flush kind
    localparam int FL_NONE  = 0;
    localparam int FL_EXCP  = 1;
    localparam int FL_ERTN  = 2;

    logic            clk;
    logic            arst_n;
    logic            left_valid;
    logic            right_ready;
    logic            icache_busy;
    logic [XLEN-1:0] pc;
    logic            inst_valid;
    logic            wreg_en;
    logic [4:0]      wreg_index;
    logic [XLEN-1:0] mem_result;
    logic [XLEN-1:0] mem_addr;
    logic [15:0]     excp_num;
    logic            ertn;
    logic            csr_we;
    csr_num_e        csr_num;
    logic [XLEN-1:0] csr_wdata;
    logic            left_ready;
    logic            right_valid;
    logic            wreg_en_out;
    logic [4:0]      wreg_index_out;
    logic [XLEN-1:0] wreg_data;
    logic            excp_flush;
    logic            ertn_flush;
    logic [XLEN-1:0] flush_pc;
    ecode_e          ecode;
    logic [8:0]      esubcode;
    logic [XLEN-1:0] badv;
    logic            badv_valid;
    logic            crmd_ie;

    // stimulus side of the table
    string           t_name      [N_TESTS];
    logic            t_csr_we    [N_TESTS];
    csr_num_e        t_csr_num   [N_TESTS];
    logic [XLEN-1:0] t_csr_wdata [N_TESTS];
    int              t_wait      [N_TESTS];
    int              t_bp        [N_TESTS];
    int              t_busy      [N_TESTS];
    logic [15:0]     t_excp      [N_TESTS];
    logic            t_ertn      [N_TESTS];
    logic            t_wen       [N_TESTS];
    logic [4:0]      t_widx      [N_TESTS];
    logic [XLEN-1:0] t_wdata     [N_TESTS];
    // expected side
    ecode_e          t_ecode     [N_TESTS];
    logic [8:0]      t_esub      [N_TESTS];
    int              t_src       [N_TESTS];
    int              t_flush     [N_TESTS];
    logic            t_wout      [N_TESTS];

    int              n_fill = 0;
    int              n_err  = 0;
    int              n_pass = 0;
    int              n_fail = 0;
    int              cycle_cnt = 0;
    int              seed;
    // reference copy of the mode bits and the return address
    logic            model_ie  = 1'b0;
    logic            model_pie = 1'b0;
    logic [XLEN-1:0] saved_era = '0;

    wb_stage UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= MAX_CYCLES);
        $display("Timeout: no finish within %0d cycles, a handshake never came", MAX_CYCLES);
        $display("Verification failed");
        $finish;
    end

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            n_err++;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            n_err++;
        end
    endtask

    task automatic add_stim(input string name, input logic we, input csr_num_e num,
                            input logic [XLEN-1:0] cdata, input int wait_c, input int bp_c,
                            input int busy_c, input logic [15:0] excp, input logic ertn_i,
                            input logic wen, input logic [4:0] widx,
                            input logic [XLEN-1:0] wd);
        t_name[n_fill]      = name;
        t_csr_we[n_fill]    = we;
        t_csr_num[n_fill]   = num;
        t_csr_wdata[n_fill] = cdata;
        t_wait[n_fill]      = wait_c;
        t_bp[n_fill]        = bp_c;
        t_busy[n_fill]      = busy_c;
        t_excp[n_fill]      = excp;
        t_ertn[n_fill]      = ertn_i;
        t_wen[n_fill]       = wen;
        t_widx[n_fill]      = widx;
        t_wdata[n_fill]     = wd;
    endtask

    task automatic add_expect(input ecode_e ec, input logic [8:0] esub, input int src,
                              input int fl, input logic wout);
        t_ecode[n_fill] = ec;
        t_esub[n_fill]  = esub;
        t_src[n_fill]   = src;
        t_flush[n_fill] = fl;
        t_wout[n_fill]  = wout;
        n_fill++;
    endtask

    task automatic build_table();
        // plain retirement and back-pressure
        add_stim("plain_write", 1'b1, CSR_EENTRY, EENTRY_VAL, 0, 0, 0, 16'h0000, 1'b0,
                 1'b1, 5'd5, 32'hCAFE_0001);
        add_expect(ECODE_INT, 9'd0, SRC_NONE, FL_NONE, 1'b1);
        add_stim("plain_nowrite", 1'b0, CSR_CRMD, '0, 0, 0, 0, 16'h0000, 1'b0,
                 1'b0, 5'd7, 32'h1234_5678);
        add_expect(ECODE_INT, 9'd0, SRC_NONE, FL_NONE, 1'b0);
        add_stim("back_pressure", 1'b0, CSR_CRMD, '0, 0, 3, 0, 16'h0000, 1'b0,
                 1'b1, 5'd9, 32'h0BAD_F00D);
        add_expect(ECODE_INT, 9'd0, SRC_NONE, FL_NONE, 1'b1);
        // several causes at once, lowest index wins
        add_stim("prio_adef", 1'b0, CSR_CRMD, '0, 0, 0, 0, 16'h0222, 1'b0,
                 1'b1, 5'd3, 32'h0000_0033);
        add_expect(ECODE_ADE, ESUBCODE_ADEF, SRC_PC, FL_EXCP, 1'b0);
        add_stim("prio_ale", 1'b0, CSR_CRMD, '0, 0, 0, 0, 16'h8600, 1'b0,
                 1'b1, 5'd4, 32'h0000_0044);
        add_expect(ECODE_ALE, 9'd0, SRC_MEM, FL_EXCP, 1'b0);
        add_stim("prio_adem", 1'b0, CSR_CRMD, '0, 0, 0, 0, 16'h8400, 1'b0,
                 1'b0, 5'd0, 32'h0000_0000);
        add_expect(ECODE_ADE, ESUBCODE_ADEM, SRC_MEM, FL_EXCP, 1'b0);
        add_stim("prio_itlbr", 1'b0, CSR_CRMD, '0, 0, 0, 0, 16'h400C, 1'b0,
                 1'b1, 5'd6, 32'h0000_0066);
        add_expect(ECODE_TLBR, 9'd0, SRC_PC, FL_EXCP, 1'b0);
        add_stim("prio_sys", 1'b0, CSR_CRMD, '0, 0, 0, 0, 16'h1060, 1'b0,
                 1'b1, 5'd8, 32'h0000_0088);
        add_expect(ECODE_SYS, 9'd0, SRC_NONE, FL_EXCP, 1'b0);
        // ie set first (bit 2), then a dtlbr held by a busy icache
        add_stim("icache_hold", 1'b1, CSR_CRMD, 32'h0000_0004, 0, 0, 4, 16'h0800, 1'b0,
                 1'b1, 5'd10, 32'h0000_00AA);
        add_expect(ECODE_TLBR, 9'd0, SRC_MEM, FL_EXCP, 1'b0);
        add_stim("ertn_return", 1'b0, CSR_CRMD, '0, 0, 0, 0, 16'h0000, 1'b1,
                 1'b0, 5'd0, 32'h0000_0000);
        add_expect(ECODE_INT, 9'd0, SRC_NONE, FL_ERTN, 1'b0);
        // timer, initval 5 with enable, one-shot
        add_stim("timer_ie", 1'b1, CSR_CRMD, 32'h0000_0004, 0, 0, 0, 16'h0000, 1'b0,
                 1'b1, 5'd11, 32'h0000_00BB);
        add_expect(ECODE_INT, 9'd0, SRC_NONE, FL_NONE, 1'b1);
        add_stim("timer_int", 1'b1, CSR_TCFG, 32'h0000_0015, 10, 0, 0, 16'h0000, 1'b0,
                 1'b1, 5'd12, 32'h0000_00CC);
        add_expect(ECODE_INT, 9'd0, SRC_NONE, FL_EXCP, 1'b0);
        add_stim("ticlr_ertn", 1'b1, CSR_TICLR, 32'h0000_0001, 0, 0, 0, 16'h0000, 1'b1,
                 1'b0, 5'd0, 32'h0000_0000);
        add_expect(ECODE_INT, 9'd0, SRC_NONE, FL_ERTN, 1'b0);
        // ie back on, pending gone
        add_stim("after_ticlr", 1'b0, CSR_CRMD, '0, 0, 0, 0, 16'h0000, 1'b0,
                 1'b1, 5'd31, 32'hFFFF_0000);
        add_expect(ECODE_INT, 9'd0, SRC_NONE, FL_NONE, 1'b1);
    endtask

    task automatic clear_inputs();
        left_valid  = 1'b0;
        right_ready = 1'b1;
        icache_busy = 1'b0;
        pc          = '0;
        inst_valid  = 1'b0;
        wreg_en     = 1'b0;
        wreg_index  = '0;
        mem_result  = '0;
        mem_addr    = '0;
        excp_num    = '0;
        ertn        = 1'b0;
        csr_we      = 1'b0;
        csr_num     = CSR_CRMD;
        csr_wdata   = '0;
    endtask

    task automatic run_entry(input int t);
        int              k;
        bit              done;
        int              err_before;
        logic [XLEN-1:0] cur_pc;
        logic [XLEN-1:0] cur_addr;
        logic [XLEN-1:0] exp_badv;
        logic [XLEN-1:0] exp_fpc;
        logic            exp_bv;
        err_before = n_err;
        k          = 0;
        done       = 1'b0;
        cur_pc     = $random(seed);
        cur_addr   = $random(seed);
        // idle head, optional csr write
        @(negedge clk);
        clear_inputs();
        if (t_csr_we[t]) begin
            csr_we    = 1'b1;
            csr_num   = t_csr_num[t];
            csr_wdata = t_csr_wdata[t];
            if (t_csr_num[t] == CSR_CRMD) begin
                model_ie = t_csr_wdata[t][CRMD_IE_BIT];
            end
        end
        // one-cycle refetch bubble right after a flush
        #1;
        if (t > 0 && t_flush[t-1] != FL_NONE) begin
            check_bit("left_ready in refetch bubble", left_ready, 1'b0);
            check_bit("excp_flush after pulse", excp_flush, 1'b0);
            check_bit("ertn_flush after pulse", ertn_flush, 1'b0);
        end
        repeat (t_wait[t]) begin
            @(negedge clk);
            csr_we = 1'b0;
        end
        // badv follows the source of the winning cause
        exp_badv = '0;
        exp_bv   = 1'b0;
        if (t_src[t] == SRC_PC) begin
            exp_badv = cur_pc;
            exp_bv   = 1'b1;
        end else if (t_src[t] == SRC_MEM) begin
            exp_badv = cur_addr;
            exp_bv   = 1'b1;
        end
        exp_fpc = (t_flush[t] == FL_ERTN) ? saved_era : EENTRY_VAL;
        while (!done) begin
            @(negedge clk);
            csr_we      = 1'b0;
            left_valid  = 1'b1;
            inst_valid  = 1'b1;
            pc          = cur_pc;
            mem_addr    = cur_addr;
            excp_num    = t_excp[t];
            ertn        = t_ertn[t];
            wreg_en     = t_wen[t];
            wreg_index  = t_widx[t];
            mem_result  = t_wdata[t];
            right_ready = (k >= t_bp[t]);
            icache_busy = (k >= t_bp[t]) && (k < t_bp[t] + t_busy[t]);
            #1;
            if (left_ready) begin
                done = 1'b1;
                check_bit("handshake cycle", k == t_bp[t] + t_busy[t], 1'b1);
                check_bit("right_valid", right_valid, 1'b1);
                check_word("ecode", 32'(ecode), 32'(t_ecode[t]));
                check_word("esubcode", 32'(esubcode), 32'(t_esub[t]));
                check_word("badv", badv, exp_badv);
                check_bit("badv_valid", badv_valid, exp_bv);
                check_bit("excp_flush", excp_flush, t_flush[t] == FL_EXCP);
                check_bit("ertn_flush", ertn_flush, t_flush[t] == FL_ERTN);
                if (t_flush[t] != FL_NONE) begin
                    check_word("flush_pc", flush_pc, exp_fpc);
                end
                check_bit("wreg_en_out", wreg_en_out, t_wout[t]);
                if (t_wout[t]) begin
                    check_word("wreg_index_out", 32'(wreg_index_out), 32'(t_widx[t]));
                    check_word("wreg_data", wreg_data, t_wdata[t]);
                end
                check_bit("crmd_ie", crmd_ie, model_ie);
            end else begin
                // held head, nothing may leave
                check_bit("excp_flush while held", excp_flush, 1'b0);
                check_bit("ertn_flush while held", ertn_flush, 1'b0);
                check_bit("wreg_en_out while held", wreg_en_out, 1'b0);
            end
            k++;
        end
        // mode bits as the csr block should see them after this edge
        if (t_flush[t] == FL_EXCP) begin
            model_pie = model_ie;
            model_ie  = 1'b0;
            saved_era = cur_pc;
        end else if (t_flush[t] == FL_ERTN) begin
            model_ie = model_pie;
        end
        if (n_err == err_before) begin
            n_pass++;
            $display("test %0d %s: ok", t, t_name[t]);
        end else begin
            n_fail++;
            $display("test %0d %s: mismatch", t, t_name[t]);
        end
    endtask

    initial begin
        seed   = 7;
        arst_n = 1'b0;
        clear_inputs();
        // consumer not ready during reset
        right_ready = 1'b0;
        build_table();
        repeat (10) @(negedge clk);
        // reset values, still in reset
        check_bit("left_ready in reset", left_ready, 1'b0);
        check_bit("right_valid in reset", right_valid, 1'b0);
        check_bit("excp_flush in reset", excp_flush, 1'b0);
        check_bit("ertn_flush in reset", ertn_flush, 1'b0);
        check_bit("wreg_en_out in reset", wreg_en_out, 1'b0);
        check_bit("crmd_ie in reset", crmd_ie, 1'b0);
        if (n_err == 0) begin
            n_pass++;
            $display("test reset: ok");
        end else begin
            n_fail++;
            $display("test reset: mismatch");
        end
        arst_n = 1'b1;
        for (int t = 0; t < N_TESTS; t++) begin
            run_entry(t);
        end
        @(negedge clk);
        clear_inputs();
        $display("summary: %0d tests, %0d passed, %0d failed, %0d value errors",
                 N_TESTS + 1, n_pass, n_fail, n_err);
        if (n_err == 0 && n_fail == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
logic/commit_pkg.sv
logic/excp_encode.sv
logic/commit_ctrl.sv
logic/stable_timer.sv
logic/excp_csr.sv
logic/wb_stage.sv
test/wb_stage_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = wb_stage_tb
FILELIST  = filelist.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf $(OBJDIR)
